/* axil_chan_watch.sv */
`default_nettype none

module axil_chan_watch #(
	parameter type T_PAYLOAD = logic
) (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_valid,
	input wire i_ready,
	input wire T_PAYLOAD i_payload,
	output logic o_unstable
);

	// Channel was stalled on the previous edge
	logic stalled_q;
	// Payload seen while stalled
	T_PAYLOAD payload_q;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			stalled_q <= 1'b0;
			o_unstable <= 1'b0;
		end
		else
		begin
			stalled_q <= i_valid && !i_ready;
			// stalled_q only sets out of reset, so both cycles are covered
			o_unstable <= stalled_q && (!i_valid || (i_payload != payload_q));
		end
	end

	// Payload as seen on the previous edge
	always_ff @(posedge i_clk)
	begin
		payload_q <= i_payload;
	end

endmodule

`default_nettype wire

/* axil_event_if.sv */
`default_nettype none

// Handshake events and outstanding counts shared by the monitor blocks
interface axil_event_if #(
	parameter int DEPTH_W = mon_pkg::DEF_DEPTH_W
);

	// Single cycle handshake pulses
	logic aw_req;
	logic w_req;
	logic ar_req;
	logic b_ack;
	logic r_ack;

	// Outstanding counts, registered
	logic [DEPTH_W-1:0] awr_cnt;
	logic [DEPTH_W-1:0] wr_cnt;
	logic [DEPTH_W-1:0] rd_cnt;

	// Owner of the events and counts
	modport counter (output aw_req, w_req, ar_req, b_ack, r_ack,
		output awr_cnt, wr_cnt, rd_cnt);

	// Timers only look
	modport observer (input aw_req, w_req, ar_req, b_ack, r_ack,
		input awr_cnt, wr_cnt, rd_cnt);

endinterface

`default_nettype wire

/* axil_monitor_top.sv */
`default_nettype none

module axil_monitor_top #(
	parameter int DEPTH_W = mon_pkg::DEF_DEPTH_W,
	parameter int MAX_WAIT = mon_pkg::DEF_MAX_WAIT,
	parameter int MAX_RSTALL = mon_pkg::DEF_MAX_RSTALL,
	parameter int MAX_DELAY = mon_pkg::DEF_MAX_DELAY
) (
	input wire i_clk,
	input wire i_axi_reset_n,
	// Write address channel
	input wire i_axi_awvalid,
	input wire i_axi_awready,
	input wire axil_pkg::addr_t i_axi_awaddr,
	// Write data channel
	input wire i_axi_wvalid,
	input wire i_axi_wready,
	input wire axil_pkg::data_t i_axi_wdata,
	input wire axil_pkg::strb_t i_axi_wstrb,
	// Write response channel
	input wire i_axi_bvalid,
	input wire i_axi_bready,
	input wire axil_pkg::resp_t i_axi_bresp,
	// Read address channel
	input wire i_axi_arvalid,
	input wire i_axi_arready,
	input wire axil_pkg::addr_t i_axi_araddr,
	// Read data channel
	input wire i_axi_rvalid,
	input wire i_axi_rready,
	input wire axil_pkg::data_t i_axi_rdata,
	input wire axil_pkg::resp_t i_axi_rresp,
	output logic [DEPTH_W-1:0] o_awr_outstanding,
	output logic [DEPTH_W-1:0] o_wr_outstanding,
	output logic [DEPTH_W-1:0] o_rd_outstanding,
	output mon_pkg::viol_vec_t o_violations
);
	import axil_pkg::*;

	wpay_t w_pay;
	rpay_t r_pay;
	logic overflow;
	logic orphan;
	logic exokay;
	logic unstable_aw;
	logic unstable_w;
	logic unstable_b;
	logic unstable_ar;
	logic unstable_r;
	logic req_stall;
	logic resp_stall;
	logic resp_delay;

	axil_event_if #(.DEPTH_W(DEPTH_W)) ev ();

	// Bundle data channel payloads for the stability checks
	assign w_pay.data = i_axi_wdata;
	assign w_pay.strb = i_axi_wstrb;
	assign r_pay.data = i_axi_rdata;
	assign r_pay.resp = i_axi_rresp;

	assign o_awr_outstanding = ev.awr_cnt;
	assign o_wr_outstanding = ev.wr_cnt;
	assign o_rd_outstanding = ev.rd_cnt;

	axil_txn_counter #(.DEPTH_W(DEPTH_W)) u_counter (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_axi_awvalid), .i_awready(i_axi_awready),
		.i_wvalid(i_axi_wvalid), .i_wready(i_axi_wready),
		.i_bvalid(i_axi_bvalid), .i_bready(i_axi_bready),
		.i_arvalid(i_axi_arvalid), .i_arready(i_axi_arready),
		.i_rvalid(i_axi_rvalid), .i_rready(i_axi_rready),
		.i_bresp(i_axi_bresp), .i_rresp(i_axi_rresp), .ev(ev),
		.o_overflow(overflow), .o_orphan(orphan), .o_exokay(exokay));

	//////////////////////////////
	// Stability, one per channel
	//////////////////////////////

	axil_chan_watch #(.T_PAYLOAD(addr_t)) u_aw_watch (.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_awvalid), .i_ready(i_axi_awready),
		.i_payload(i_axi_awaddr), .o_unstable(unstable_aw));
	axil_chan_watch #(.T_PAYLOAD(wpay_t)) u_w_watch (.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_wvalid), .i_ready(i_axi_wready),
		.i_payload(w_pay), .o_unstable(unstable_w));
	axil_chan_watch #(.T_PAYLOAD(resp_t)) u_b_watch (.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_bvalid), .i_ready(i_axi_bready),
		.i_payload(i_axi_bresp), .o_unstable(unstable_b));
	axil_chan_watch #(.T_PAYLOAD(addr_t)) u_ar_watch (.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_arvalid), .i_ready(i_axi_arready),
		.i_payload(i_axi_araddr), .o_unstable(unstable_ar));
	axil_chan_watch #(.T_PAYLOAD(rpay_t)) u_r_watch (.i_clk(i_clk),
		.i_axi_reset_n(i_axi_reset_n), .i_valid(i_axi_rvalid), .i_ready(i_axi_rready),
		.i_payload(r_pay), .o_unstable(unstable_r));

	axil_stall_timers #(.DEPTH_W(DEPTH_W), .MAX_WAIT(MAX_WAIT),
		.MAX_RSTALL(MAX_RSTALL)) u_stall (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_awvalid(i_axi_awvalid), .i_awready(i_axi_awready),
		.i_wvalid(i_axi_wvalid), .i_wready(i_axi_wready),
		.i_bvalid(i_axi_bvalid), .i_bready(i_axi_bready),
		.i_arvalid(i_axi_arvalid), .i_arready(i_axi_arready),
		.i_rvalid(i_axi_rvalid), .i_rready(i_axi_rready), .ev(ev),
		.o_req_stall(req_stall), .o_resp_stall(resp_stall));

	axil_resp_timers #(.DEPTH_W(DEPTH_W), .MAX_DELAY(MAX_DELAY)) u_delay (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n), .i_bvalid(i_axi_bvalid),
		.i_rvalid(i_axi_rvalid), .ev(ev), .o_resp_delay(resp_delay));

	// All checker pulses meet here
	axil_violation_log u_log (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_overflow(overflow), .i_orphan(orphan), .i_exokay(exokay),
		.i_unstable_aw(unstable_aw), .i_unstable_w(unstable_w),
		.i_unstable_b(unstable_b), .i_unstable_ar(unstable_ar),
		.i_unstable_r(unstable_r), .i_req_stall(req_stall),
		.i_resp_stall(resp_stall), .i_resp_delay(resp_delay),
		.o_violations(o_violations));

endmodule

`default_nettype wire

/* axil_pkg.sv */
`default_nettype none

package axil_pkg;

	// Widths of the monitored AXI4-Lite link
	localparam int AXI_ADDR_W = 28;
	localparam int AXI_DATA_W = 32;

	typedef logic [AXI_ADDR_W-1:0] addr_t;
	typedef logic [AXI_DATA_W-1:0] data_t;
	typedef logic [AXI_DATA_W/8-1:0] strb_t;
	typedef logic [1:0] resp_t;

	// Response codes
	localparam resp_t RESP_OKAY = 2'b00;
	// Exclusive access is not supported, so this code is illegal here
	localparam resp_t RESP_EXOKAY = 2'b01;
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

	// Write data channel payload
	typedef struct packed {
		data_t data;
		strb_t strb;
	} wpay_t;

	// Read data channel payload
	typedef struct packed {
		data_t data;
		resp_t resp;
	} rpay_t;

endpackage

`default_nettype wire

/* axil_resp_timers.sv */
`default_nettype none

module axil_resp_timers #(
	parameter int DEPTH_W = mon_pkg::DEF_DEPTH_W,
	parameter int MAX_DELAY = mon_pkg::DEF_MAX_DELAY
) (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_bvalid,
	input wire i_rvalid,
	axil_event_if.observer ev,
	output logic o_resp_delay
);
	import mon_pkg::*;

	localparam logic [TIMER_W-1:0] DELAY_LIM = TIMER_W'(MAX_DELAY);

	logic [DEPTH_W-1:0] awr_cnt;
	logic [DEPTH_W-1:0] wr_cnt;
	logic [DEPTH_W-1:0] rd_cnt;
	// Slot 0 is writes, slot 1 is reads
	logic [1:0] waiting;
	logic [1:0] hit;
	logic [TIMER_W-1:0] timer [2];

	assign awr_cnt = ev.awr_cnt;
	assign wr_cnt = ev.wr_cnt;
	assign rd_cnt = ev.rd_cnt;

	// A write needs both halves in before its response is due
	assign waiting[0] = (awr_cnt != '0) && (wr_cnt != '0) && !i_bvalid;
	assign waiting[1] = (rd_cnt != '0) && !i_rvalid;

	// Count while a response is owed and not yet offered
	always_ff @(posedge i_clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (!i_axi_reset_n || !waiting[i])
			begin
				timer[i] <= '0;
				hit[i] <= 1'b0;
			end
			else
			begin
				if (timer[i] != DELAY_LIM)
					timer[i] <= timer[i] + 1'b1;
				hit[i] <= (timer[i] == (DELAY_LIM - 1'b1));
			end
		end
	end

	assign o_resp_delay = |hit;

endmodule

`default_nettype wire

/* axil_stall_timers.sv */
`default_nettype none

module axil_stall_timers #(
	parameter int DEPTH_W = mon_pkg::DEF_DEPTH_W,
	parameter int MAX_WAIT = mon_pkg::DEF_MAX_WAIT,
	parameter int MAX_RSTALL = mon_pkg::DEF_MAX_RSTALL
) (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_awvalid,
	input wire i_awready,
	input wire i_wvalid,
	input wire i_wready,
	input wire i_bvalid,
	input wire i_bready,
	input wire i_arvalid,
	input wire i_arready,
	input wire i_rvalid,
	input wire i_rready,
	axil_event_if.observer ev,
	output logic o_req_stall,
	output logic o_resp_stall
);
	import mon_pkg::*;

	// Channel slots, requests first
	localparam int CH_AW = 0;
	localparam int CH_W = 1;
	localparam int CH_AR = 2;
	localparam int CH_B = 3;
	localparam int CH_R = 4;
	localparam int N_CH = 5;

	localparam logic [TIMER_W-1:0] WAIT_LIM = TIMER_W'(MAX_WAIT);
	localparam logic [TIMER_W-1:0] RSTALL_LIM = TIMER_W'(MAX_RSTALL);

	logic [DEPTH_W-1:0] awr_cnt;
	logic [DEPTH_W-1:0] wr_cnt;
	logic [N_CH-1:0] stalled;
	logic [N_CH-1:0] exempt;
	logic [N_CH-1:0] hit;
	logic [TIMER_W-1:0] timer [N_CH];

	function automatic logic [TIMER_W-1:0] chan_limit(input int ch);
		return (ch >= CH_B) ? RSTALL_LIM : WAIT_LIM;
	endfunction

	assign awr_cnt = ev.awr_cnt;
	assign wr_cnt = ev.wr_cnt;

	// Valid held against a low ready
	assign stalled[CH_AW] = i_awvalid && !i_awready;
	assign stalled[CH_W] = i_wvalid && !i_wready;
	assign stalled[CH_AR] = i_arvalid && !i_arready;
	assign stalled[CH_B] = i_bvalid && !i_bready;
	assign stalled[CH_R] = i_rvalid && !i_rready;

	//////////////////////////////
	// Exemptions
	//////////////////////////////

	// Pending response backs up the request side
	// Address may wait for its matching data, and data for its address
	assign exempt[CH_AW] = i_bvalid || (i_awvalid && !i_wvalid && (awr_cnt >= wr_cnt));
	assign exempt[CH_W] = i_bvalid || (i_wvalid && !i_awvalid && (wr_cnt >= awr_cnt));
	assign exempt[CH_AR] = i_rvalid;
	assign exempt[CH_B] = 1'b0;
	assign exempt[CH_R] = 1'b0;

	// Timers hold at the limit, hit pulses on arrival
	always_ff @(posedge i_clk)
	begin
		for (int i = 0; i < N_CH; i++)
		begin
			if (!i_axi_reset_n || !stalled[i] || exempt[i])
			begin
				timer[i] <= '0;
				hit[i] <= 1'b0;
			end
			else
			begin
				if (timer[i] != chan_limit(i))
					timer[i] <= timer[i] + 1'b1;
				hit[i] <= (timer[i] == (chan_limit(i) - 1'b1));
			end
		end
	end

	assign o_req_stall = hit[CH_AW] || hit[CH_W] || hit[CH_AR];
	assign o_resp_stall = hit[CH_B] || hit[CH_R];

	// No timer ever runs past its limit
	for (genvar g = 0; g < N_CH; g++)
	begin : g_limit_chk
		a_timer_cap: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
			(timer[g] <= chan_limit(g)));
	end

endmodule

`default_nettype wire

/* axil_txn_counter.sv */
`default_nettype none

module axil_txn_counter #(
	parameter int DEPTH_W = mon_pkg::DEF_DEPTH_W
) (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_awvalid,
	input wire i_awready,
	input wire i_wvalid,
	input wire i_wready,
	input wire i_bvalid,
	input wire i_bready,
	input wire i_arvalid,
	input wire i_arready,
	input wire i_rvalid,
	input wire i_rready,
	input wire axil_pkg::resp_t i_bresp,
	input wire axil_pkg::resp_t i_rresp,
	axil_event_if.counter ev,
	output logic o_overflow,
	output logic o_orphan,
	output logic o_exokay
);
	import axil_pkg::*;

	// Saturation point and the value just below it
	localparam logic [DEPTH_W-1:0] CNT_MAX = {DEPTH_W{1'b1}};
	localparam logic [DEPTH_W-1:0] CNT_TOP = CNT_MAX - 1'b1;

	// Next count, held at both ends
	function automatic logic [DEPTH_W-1:0] step(input logic [DEPTH_W-1:0] cnt,
		input logic inc, input logic dec);
		logic [DEPTH_W-1:0] nxt;
		nxt = cnt;
		if (inc && !dec && (cnt != CNT_MAX))
			nxt = cnt + 1'b1;
		else if (dec && !inc && (cnt != '0))
			nxt = cnt - 1'b1;
		return nxt;
	endfunction

	// A request that drives a count onto or past all ones
	function automatic logic hits_top(input logic [DEPTH_W-1:0] cnt,
		input logic inc, input logic dec);
		return inc && !dec && (cnt >= CNT_TOP);
	endfunction

	//////////////////////////////
	// Handshake detection
	//////////////////////////////

	assign ev.aw_req = i_awvalid && i_awready;
	assign ev.w_req = i_wvalid && i_wready;
	assign ev.ar_req = i_arvalid && i_arready;
	// A write response retires both the address and the data
	assign ev.b_ack = i_bvalid && i_bready;
	assign ev.r_ack = i_rvalid && i_rready;

	//////////////////////////////
	// Outstanding counts and checks
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			ev.awr_cnt <= '0;
			ev.wr_cnt <= '0;
			ev.rd_cnt <= '0;
			o_overflow <= 1'b0;
			o_orphan <= 1'b0;
			o_exokay <= 1'b0;
		end
		else
		begin
			ev.awr_cnt <= step(ev.awr_cnt, ev.aw_req, ev.b_ack);
			ev.wr_cnt <= step(ev.wr_cnt, ev.w_req, ev.b_ack);
			ev.rd_cnt <= step(ev.rd_cnt, ev.ar_req, ev.r_ack);
			o_overflow <= hits_top(ev.awr_cnt, ev.aw_req, ev.b_ack)
				|| hits_top(ev.wr_cnt, ev.w_req, ev.b_ack)
				|| hits_top(ev.rd_cnt, ev.ar_req, ev.r_ack);
			// Response with nothing in flight to answer
			o_orphan <= (i_bvalid && ((ev.awr_cnt == '0) || (ev.wr_cnt == '0)))
				|| (i_rvalid && (ev.rd_cnt == '0));
			o_exokay <= (i_bvalid && (i_bresp == RESP_EXOKAY))
				|| (i_rvalid && (i_rresp == RESP_EXOKAY));
		end
	end

	// A response at count zero leaves the count at zero and is reported
	a_no_silent_underflow_awr: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(ev.b_ack && !ev.aw_req && (ev.awr_cnt == '0)) |=> (o_orphan && (ev.awr_cnt == '0)));
	a_no_silent_underflow_wr: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(ev.b_ack && !ev.w_req && (ev.wr_cnt == '0)) |=> (o_orphan && (ev.wr_cnt == '0)));
	a_no_silent_underflow_rd: assert property (@(posedge i_clk) disable iff (!i_axi_reset_n)
		(ev.r_ack && !ev.ar_req && (ev.rd_cnt == '0)) |=> (o_orphan && (ev.rd_cnt == '0)));

endmodule

`default_nettype wire

/* axil_violation_log.sv */
`default_nettype none

module axil_violation_log (
	input wire i_clk,
	input wire i_axi_reset_n,
	input wire i_overflow,
	input wire i_orphan,
	input wire i_exokay,
	input wire i_unstable_aw,
	input wire i_unstable_w,
	input wire i_unstable_b,
	input wire i_unstable_ar,
	input wire i_unstable_r,
	input wire i_req_stall,
	input wire i_resp_stall,
	input wire i_resp_delay,
	output mon_pkg::viol_vec_t o_violations
);
	import mon_pkg::*;

	// New violations this cycle
	viol_vec_t set;

	always_comb
	begin
		set = '0;
		set[V_OVERFLOW] = i_overflow;
		set[V_ORPHAN_RESP] = i_orphan;
		set[V_EXOKAY_RESP] = i_exokay;
		// Any channel losing its payload or valid
		set[V_UNSTABLE] = i_unstable_aw || i_unstable_w || i_unstable_b
			|| i_unstable_ar || i_unstable_r;
		set[V_REQ_STALL] = i_req_stall;
		set[V_RESP_STALL] = i_resp_stall;
		set[V_RESP_DELAY] = i_resp_delay;
	end

	//////////////////////////////
	// Sticky flags
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
			o_violations <= '0;
		else
			o_violations <= o_violations | set;
	end

	// Flags only ever accumulate between resets
	a_sticky: assert property (@(posedge i_clk)
		i_axi_reset_n |=> ((o_violations & $past(o_violations)) == $past(o_violations)));

endmodule

`default_nettype wire

/* mon_pkg.sv */
`default_nettype none

package mon_pkg;

	// Bit positions in the violation vector
	typedef enum logic [2:0] {
		V_OVERFLOW    = 3'd0,
		V_ORPHAN_RESP = 3'd1,
		V_EXOKAY_RESP = 3'd2,
		V_UNSTABLE    = 3'd3,
		V_REQ_STALL   = 3'd4,
		V_RESP_STALL  = 3'd5,
		V_RESP_DELAY  = 3'd6
	} viol_e;

	localparam int N_VIOL = 7;

	// One sticky flag per violation kind
	typedef logic [N_VIOL-1:0] viol_vec_t;

	// Outstanding counter width
	localparam int DEF_DEPTH_W = 4;

	// Default timeouts, in clock cycles
	localparam int DEF_MAX_WAIT = 12;
	localparam int DEF_MAX_RSTALL = 12;
	localparam int DEF_MAX_DELAY = 12;

	// Wide enough for any limit up to 15
	localparam int TIMER_W = 4;

endpackage

`default_nettype wire

/* src.f */
axil_pkg.sv
mon_pkg.sv
axil_event_if.sv
axil_txn_counter.sv
axil_chan_watch.sv
axil_stall_timers.sv
axil_resp_timers.sv
axil_violation_log.sv
axil_monitor_top.sv
tb_axil_monitor.sv

/* tb_axil_monitor.sv */
`default_nettype none

module tb_axil_monitor;
	import axil_pkg::*;
	import mon_pkg::*;

	localparam int SEED = 19998;
	localparam int RST_CYCLES = 10;
	localparam int HS_WAIT = 40;
	localparam int FLAG_WAIT = 24;
	localparam int CNT_MAX = (1 << DEF_DEPTH_W) - 1;
	// Channel selectors for the handshake helpers
	localparam int CH_AW = 0;
	localparam int CH_W = 1;
	localparam int CH_B = 2;
	localparam int CH_AR = 3;
	localparam int CH_R = 4;
	// Fault injected by each scenario
	localparam int F_NONE = 0;
	localparam int F_ORPHAN = 1;
	localparam int F_UNSTABLE = 2;
	localparam int F_STALL = 3;
	localparam int F_DELAY_EXOKAY = 4;
	localparam int F_OVERFLOW = 5;

	logic i_clk = 1'b0;
	logic i_axi_reset_n;
	logic i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready;
	logic i_axi_bvalid, i_axi_bready, i_axi_arvalid, i_axi_arready;
	logic i_axi_rvalid, i_axi_rready;
	addr_t i_axi_awaddr, i_axi_araddr;
	data_t i_axi_wdata, i_axi_rdata;
	strb_t i_axi_wstrb;
	resp_t i_axi_bresp, i_axi_rresp;
	logic [DEF_DEPTH_W-1:0] o_awr_outstanding, o_wr_outstanding, o_rd_outstanding;
	viol_vec_t o_violations;

	// Reference model state, updated on the rising edge
	int m_awr = 0;
	int m_wr = 0;
	int m_rd = 0;
	int m_orphans = 0;
	bit m_live = 1'b0;
	int cur_fault = F_NONE;
	int err_value = 0;
	int err_timeout = 0;
	event scen_end;

	always #5 i_clk = ~i_clk;

	axil_monitor_top dut_i (
		.i_clk(i_clk), .i_axi_reset_n(i_axi_reset_n),
		.i_axi_awvalid(i_axi_awvalid), .i_axi_awready(i_axi_awready),
		.i_axi_awaddr(i_axi_awaddr),
		.i_axi_wvalid(i_axi_wvalid), .i_axi_wready(i_axi_wready),
		.i_axi_wdata(i_axi_wdata), .i_axi_wstrb(i_axi_wstrb),
		.i_axi_bvalid(i_axi_bvalid), .i_axi_bready(i_axi_bready), .i_axi_bresp(i_axi_bresp),
		.i_axi_arvalid(i_axi_arvalid), .i_axi_arready(i_axi_arready),
		.i_axi_araddr(i_axi_araddr),
		.i_axi_rvalid(i_axi_rvalid), .i_axi_rready(i_axi_rready),
		.i_axi_rdata(i_axi_rdata), .i_axi_rresp(i_axi_rresp),
		.o_awr_outstanding(o_awr_outstanding), .o_wr_outstanding(o_wr_outstanding),
		.o_rd_outstanding(o_rd_outstanding), .o_violations(o_violations));

	// Request adds one, response removes one, both together cancel
	function automatic int advance_count(input int cnt, input bit inc, input bit dec);
		if (inc && !dec)
			return (cnt < CNT_MAX) ? cnt + 1 : cnt;
		if (dec && !inc)
			return (cnt > 0) ? cnt - 1 : cnt;
		return cnt;
	endfunction

	function automatic viol_vec_t single_flag(input viol_e v);
		viol_vec_t m;
		m = '0;
		m[v] = 1'b1;
		return m;
	endfunction

	//////////////////////////////
	// Reference flags
	//////////////////////////////

	function automatic viol_vec_t expected_flags(input int fault, input int awr, input int wr,
		input int rd, input int orphans);
		viol_vec_t v;
		v = '0;
		// Saturated counts and orphan responses come from the model
		if ((awr == CNT_MAX) || (wr == CNT_MAX) || (rd == CNT_MAX))
			v[V_OVERFLOW] = 1'b1;
		if (orphans != 0)
			v[V_ORPHAN_RESP] = 1'b1;
		case (fault)
			F_UNSTABLE: v[V_UNSTABLE] = 1'b1;
			F_STALL:
			begin
				v[V_REQ_STALL] = 1'b1;
				v[V_RESP_STALL] = 1'b1;
			end
			F_DELAY_EXOKAY:
			begin
				v[V_RESP_DELAY] = 1'b1;
				v[V_EXOKAY_RESP] = 1'b1;
			end
			// Unanswered reads also outlast the delay limit
			F_OVERFLOW: v[V_RESP_DELAY] = 1'b1;
			default: v = v;
		endcase
		return v;
	endfunction

	// Model follows handshakes seen on the rising edge
	always @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			m_awr <= 0;
			m_wr <= 0;
			m_rd <= 0;
			m_orphans <= 0;
		end
		else
		begin
			m_awr <= advance_count(m_awr, i_axi_awvalid && i_axi_awready,
				i_axi_bvalid && i_axi_bready);
			m_wr <= advance_count(m_wr, i_axi_wvalid && i_axi_wready,
				i_axi_bvalid && i_axi_bready);
			m_rd <= advance_count(m_rd, i_axi_arvalid && i_axi_arready,
				i_axi_rvalid && i_axi_rready);
			// An offered response with nothing outstanding is already an orphan
			if ((i_axi_bvalid && ((m_awr == 0) || (m_wr == 0)))
				|| (i_axi_rvalid && (m_rd == 0)))
				m_orphans <= m_orphans + 1;
		end
		m_live <= i_axi_reset_n;
	end

	//////////////////////////////
	// Compare process
	//////////////////////////////

	// Counts settle on the rising edge, so compare on the falling one
	always @(negedge i_clk)
	begin
		if (m_live)
		begin
			assert (o_awr_outstanding == m_awr) else
			begin
				err_value++;
				$display("ERROR %0t: awr outstanding %0d, expected %0d", $time,
					o_awr_outstanding, m_awr);
			end
			assert (o_wr_outstanding == m_wr) else
			begin
				err_value++;
				$display("ERROR %0t: wr outstanding %0d, expected %0d", $time,
					o_wr_outstanding, m_wr);
			end
			assert (o_rd_outstanding == m_rd) else
			begin
				err_value++;
				$display("ERROR %0t: rd outstanding %0d, expected %0d", $time,
					o_rd_outstanding, m_rd);
			end
		end
	end

	always @(scen_end)
	begin
		assert (o_violations == expected_flags(cur_fault, m_awr, m_wr, m_rd, m_orphans)) else
		begin
			err_value++;
			$display("ERROR %0t: scenario %0d flags %b, expected %b", $time, cur_fault,
				o_violations, expected_flags(cur_fault, m_awr, m_wr, m_rd, m_orphans));
		end
	end

	//////////////////////////////
	// Bus driving helpers
	//////////////////////////////

	task automatic drive_idle;
		{i_axi_awvalid, i_axi_awready, i_axi_wvalid, i_axi_wready} = '0;
		{i_axi_bvalid, i_axi_bready, i_axi_arvalid, i_axi_arready} = '0;
		{i_axi_rvalid, i_axi_rready} = '0;
		i_axi_awaddr = '0;
		i_axi_araddr = '0;
		i_axi_wdata = '0;
		i_axi_rdata = '0;
		i_axi_wstrb = '0;
		i_axi_bresp = RESP_OKAY;
		i_axi_rresp = RESP_OKAY;
	endtask

	task automatic set_ready(input int ch, input logic v);
		case (ch)
			CH_AW: i_axi_awready = v;
			CH_W: i_axi_wready = v;
			CH_B: i_axi_bready = v;
			CH_AR: i_axi_arready = v;
			default: i_axi_rready = v;
		endcase
	endtask

	function automatic logic handshake_seen(input int ch);
		case (ch)
			CH_AW: return i_axi_awvalid && i_axi_awready;
			CH_W: return i_axi_wvalid && i_axi_wready;
			CH_B: return i_axi_bvalid && i_axi_bready;
			CH_AR: return i_axi_arvalid && i_axi_arready;
			default: return i_axi_rvalid && i_axi_rready;
		endcase
	endfunction

	// Raise ready after dly cycles and wait for the handshake edge
	task automatic accept(input int ch, input int dly);
		int n;
		logic done;
		n = 0;
		done = 1'b0;
		set_ready(ch, dly == 0);
		while (!done && (n < HS_WAIT))
		begin
			@(posedge i_clk);
			done = handshake_seen(ch);
			@(negedge i_clk);
			n++;
			if (!done)
				set_ready(ch, n >= dly);
		end
		set_ready(ch, 1'b0);
		if (!done)
		begin
			err_timeout++;
			$display("No handshake on channel %0d within %0d cycles", ch, HS_WAIT);
		end
	endtask

	// Wait for the given flags, then a few cycles for stray ones
	task automatic wait_flags(input viol_vec_t exp);
		int n;
		n = 0;
		while (((o_violations & exp) != exp) && (n < FLAG_WAIT))
		begin
			@(negedge i_clk);
			n++;
		end
		if ((o_violations & exp) != exp)
		begin
			err_timeout++;
			$display("Violation flags %b never appeared, flags read %b", exp, o_violations);
		end
		repeat (4) @(negedge i_clk);
	endtask

	task automatic apply_reset;
		drive_idle();
		i_axi_reset_n = 1'b0;
		repeat (RST_CYCLES) @(negedge i_clk);
		i_axi_reset_n = 1'b1;
		@(negedge i_clk);
		assert (o_violations == '0) else
		begin
			err_value++;
			$display("ERROR %0t: flags %b after reset, expected zero", $time, o_violations);
		end
	endtask

	task automatic finish_scenario(input int fault);
		cur_fault = fault;
		-> scen_end;
		@(negedge i_clk);
	endtask

	// Address and data together, then the response
	task automatic run_write;
		i_axi_awaddr = addr_t'($urandom);
		i_axi_wdata = $urandom;
		i_axi_wstrb = strb_t'($urandom);
		i_axi_awvalid = 1'b1;
		i_axi_wvalid = 1'b1;
		accept(CH_AW, $urandom_range(3));
		i_axi_awvalid = 1'b0;
		accept(CH_W, $urandom_range(3));
		i_axi_wvalid = 1'b0;
		i_axi_bresp = $urandom_range(1) ? RESP_SLVERR : RESP_OKAY;
		i_axi_bvalid = 1'b1;
		accept(CH_B, $urandom_range(3));
		i_axi_bvalid = 1'b0;
	endtask

	task automatic run_read;
		i_axi_araddr = addr_t'($urandom);
		i_axi_arvalid = 1'b1;
		accept(CH_AR, $urandom_range(3));
		i_axi_arvalid = 1'b0;
		i_axi_rdata = $urandom;
		case ($urandom_range(2))
			0: i_axi_rresp = RESP_OKAY;
			1: i_axi_rresp = RESP_SLVERR;
			default: i_axi_rresp = RESP_DECERR;
		endcase
		i_axi_rvalid = 1'b1;
		accept(CH_R, $urandom_range(3));
		i_axi_rvalid = 1'b0;
	endtask

	//////////////////////////////
	// Scenarios
	//////////////////////////////

	initial
	begin
		int unsigned seed_val;
		seed_val = $urandom(SEED);

		// Legal traffic with short back-pressure
		apply_reset();
		for (int i = 0; i < 24; i++)
		begin
			if ($urandom_range(1))
				run_write();
			else
				run_read();
		end
		wait_flags(expected_flags(F_NONE, m_awr, m_wr, m_rd, m_orphans));
		finish_scenario(F_NONE);

		// Write response with nothing outstanding
		apply_reset();
		i_axi_bvalid = 1'b1;
		accept(CH_B, 0);
		i_axi_bvalid = 1'b0;
		wait_flags(expected_flags(F_ORPHAN, m_awr, m_wr, m_rd, m_orphans));
		finish_scenario(F_ORPHAN);

		// Address moves under a stalled awvalid
		apply_reset();
		i_axi_awaddr = addr_t'($urandom);
		i_axi_awvalid = 1'b1;
		@(negedge i_clk);
		i_axi_awaddr = i_axi_awaddr ^ addr_t'(1);
		wait_flags(expected_flags(F_UNSTABLE, m_awr, m_wr, m_rd, m_orphans));
		i_axi_awvalid = 1'b0;
		finish_scenario(F_UNSTABLE);

		// Read request stall, then read response stall
		apply_reset();
		i_axi_araddr = addr_t'($urandom);
		i_axi_arvalid = 1'b1;
		wait_flags(single_flag(V_REQ_STALL));
		accept(CH_AR, 0);
		i_axi_arvalid = 1'b0;
		i_axi_rdata = $urandom;
		i_axi_rresp = RESP_OKAY;
		i_axi_rvalid = 1'b1;
		wait_flags(single_flag(V_RESP_STALL));
		accept(CH_R, 0);
		i_axi_rvalid = 1'b0;
		finish_scenario(F_STALL);

		// Late read response carrying the exclusive-okay code
		apply_reset();
		i_axi_araddr = addr_t'($urandom);
		i_axi_arvalid = 1'b1;
		accept(CH_AR, 0);
		i_axi_arvalid = 1'b0;
		wait_flags(single_flag(V_RESP_DELAY));
		i_axi_rresp = RESP_EXOKAY;
		i_axi_rvalid = 1'b1;
		accept(CH_R, 0);
		i_axi_rvalid = 1'b0;
		wait_flags(expected_flags(F_DELAY_EXOKAY, m_awr, m_wr, m_rd, m_orphans));
		finish_scenario(F_DELAY_EXOKAY);

		// Back-to-back reads until the read count saturates
		apply_reset();
		i_axi_arvalid = 1'b1;
		for (int i = 0; i < CNT_MAX; i++)
		begin
			i_axi_araddr = addr_t'(i * 4);
			accept(CH_AR, 0);
		end
		i_axi_arvalid = 1'b0;
		wait_flags(expected_flags(F_OVERFLOW, m_awr, m_wr, m_rd, m_orphans));
		assert (o_rd_outstanding == CNT_MAX) else
		begin
			err_value++;
			$display("ERROR %0t: rd outstanding %0d, expected %0d", $time,
				o_rd_outstanding, CNT_MAX);
		end
		finish_scenario(F_OVERFLOW);

		$display("Checks done: %0d value errors, %0d timeouts", err_value, err_timeout);
		if ((err_value == 0) && (err_timeout == 0))
		begin
			$display("Simulation PASSED");
		end
		else
		begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
